// File: vlog.f
verilog/pkt_pkg.sv
verilog/sram_if.sv
verilog/packet_sram.sv
verilog/edge_wb_arbiter.sv
verilog/packet_cntl.sv
verilog/packet_fifo.sv
verilog/packet_store_top.sv
dv/packet_store_chk.sv
dv/packet_store_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = packet_store_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/packet_store_tb.sv
// Packet store testbench
// Random datapath and edge PE traffic with a scoreboard on the output stream,
// back-pressure, stall and replay phases

`timescale 1ns/1ns

module packet_store_tb;

    localparam int DEPTH       = 16;
    localparam int NUM_EDGE_PE = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int TEST_CYCLES = 1500;

    logic                    clk;
    logic                    reset;
    logic                    dp_valid;
    pkt_pkg::packet_t        dp_packet;
    logic                    dp_ready;
    logic [NUM_EDGE_PE-1:0]  edge_valid;
    pkt_pkg::packet_t        edge_packet [NUM_EDGE_PE];
    logic [NUM_EDGE_PE-1:0]  edge_ready;
    logic                    out_valid;
    pkt_pkg::packet_t        out_packet;
    logic                    out_ready;
    logic                    cntl_done;
    logic                    replay_iter;

    // Scoreboard in order of accepted input handshakes
    pkt_pkg::packet_t        expected_q [$];
    logic                    dp_fired;
    logic [NUM_EDGE_PE-1:0]  edge_fired;
    int                      accepted;
    int                      delivered;
    int                      edge_wait [NUM_EDGE_PE];

    packet_store_top #(
        .DEPTH       (DEPTH),
        .NUM_EDGE_PE (NUM_EDGE_PE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .dp_valid    (dp_valid),
        .dp_packet   (dp_packet),
        .dp_ready    (dp_ready),
        .edge_valid  (edge_valid),
        .edge_packet (edge_packet),
        .edge_ready  (edge_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet),
        .out_ready   (out_ready),
        .cntl_done   (cntl_done),
        .replay_iter (replay_iter)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        #(TEST_CYCLES * 4 * 100);
        report_failure($sformatf("Timeout: test did not finish within %0d cycles",
                                 TEST_CYCLES * 4));
    end

    // Handshakes sampled mid-cycle, where every signal has settled
    always @(negedge clk) begin
        pkt_pkg::packet_t exp_pkt;
        dp_fired   = dp_valid && dp_ready;
        edge_fired = edge_valid & edge_ready;
        if (!reset) begin
            if (out_valid && out_ready) begin
                assert (expected_q.size() != 0)
                    else report_failure("Output handshake with no packet outstanding");
                exp_pkt = expected_q.pop_front();
                assert (out_packet == exp_pkt)
                    else report_failure($sformatf("Fail at %0t: out_packet %h, expected %h",
                                                  $time, out_packet, exp_pkt));
                delivered++;
            end
            assert (!(dp_valid && edge_ready != '0))
                else report_failure($sformatf("Fail at %0t: edge_ready %b with dp_valid high",
                                              $time, edge_ready));
            if (dp_fired) begin
                expected_q.push_back(dp_packet);
                accepted++;
            end
            if (edge_fired != '0) begin
                for (int i = 0; i < NUM_EDGE_PE; i++) begin
                    if (edge_fired[i]) begin
                        expected_q.push_back(edge_packet[i]);
                        accepted++;
                        edge_wait[i] = 0;
                    end else begin
                        edge_wait[i] = edge_valid[i] ? edge_wait[i] + 1 : 0;
                    end
                    assert (edge_wait[i] < NUM_EDGE_PE)
                        else report_failure($sformatf("Fail at %0t: edge PE %0d passed over %0d times",
                                                      $time, i, edge_wait[i]));
                end
            end
            // Old iteration is discarded by the store
            if (replay_iter) begin
                expected_q.delete();
                foreach (edge_wait[i]) edge_wait[i] = 0;
            end
        end
    end

    // Producers hold valid and packet until their handshake
    task automatic drive_cycle(input int dp_pct, input int edge_pct, input int ready_pct);
        @(posedge clk);
        #5;
        if (!dp_valid || dp_fired) begin
            dp_valid  = ($urandom % 100) < dp_pct;
            dp_packet = $urandom;
        end
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (!edge_valid[i] || edge_fired[i]) begin
                edge_valid[i]  = ($urandom % 100) < edge_pct;
                edge_packet[i] = $urandom;
            end
        end
        out_ready = ($urandom % 100) < ready_pct;
    endtask

    // Finish pending producers and empty the store
    task automatic settle(input int max_cycles);
        int n;
        n = 0;
        while (dp_valid || edge_valid != '0 || expected_q.size() != 0) begin
            if (n == max_cycles) begin
                report_failure($sformatf("Store did not drain within %0d cycles", max_cycles));
            end
            drive_cycle(0, 0, 100);
            n++;
        end
    endtask

    initial begin
        void'($urandom(32'h516a));
        reset       = 1'b1;
        dp_valid    = 1'b0;
        dp_packet   = '0;
        edge_valid  = '0;
        out_ready   = 1'b0;
        cntl_done   = 1'b0;
        replay_iter = 1'b0;
        accepted    = 0;
        delivered   = 0;
        foreach (edge_packet[i]) edge_packet[i] = '0;
        foreach (edge_wait[i]) edge_wait[i] = 0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        // Mixed traffic with random output stalls
        repeat (300) drive_cycle(50, 40, 70);
        settle(200);

        // Every edge PE busy, datapath quiet
        repeat (60) drive_cycle(0, 100, 100);
        settle(200);

        // Output blocked, ring and FIFO fill up
        accepted = 0;
        repeat (80) drive_cycle(100, 100, 0);
        assert (accepted == DEPTH + FIFO_DEPTH)
            else report_failure($sformatf("Fail at %0t: %0d accepted while blocked, expected %0d",
                                          $time, accepted, DEPTH + FIFO_DEPTH));
        settle(200);

        // Fill the FIFO, then stall
        repeat (30) drive_cycle(50, 0, 0);
        cntl_done = 1'b1;
        drive_cycle(100, 100, 0);
        accepted  = 0;
        delivered = 0;
        repeat (20) drive_cycle(100, 100, 100);
        assert (accepted == 0 && delivered == FIFO_DEPTH)
            else report_failure($sformatf("Fail at %0t: stall accepted %0d, drained %0d",
                                          $time, accepted, delivered));

        // New iteration
        cntl_done   = 1'b0;
        replay_iter = 1'b1;
        drive_cycle(50, 40, 100);
        replay_iter = 1'b0;
        repeat (200) drive_cycle(50, 40, 70);
        settle(200);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: dv/packet_store_chk.sv
// Packet store protocol checker
// Valid/ready rules at the ports and the stall behavior of the controller

`timescale 1ns/1ns

module packet_store_chk #(
    parameter int NUM_EDGE_PE = 4
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    dp_valid,
    input pkt_pkg::packet_t        dp_packet,
    input logic                    dp_ready,
    input logic [NUM_EDGE_PE-1:0]  edge_valid,
    input pkt_pkg::packet_t        edge_packet [NUM_EDGE_PE],
    input logic [NUM_EDGE_PE-1:0]  edge_ready,
    input logic                    out_valid,
    input pkt_pkg::packet_t        out_packet,
    input logic                    out_ready,
    input logic                    cntl_done,
    input logic                    replay_iter
);

    dp_hold: assert property (@(posedge clk) disable iff (reset)
        dp_valid && !dp_ready |=> dp_valid && $stable(dp_packet))
        else $error("datapath packet dropped or changed before acceptance");

    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_edge_hold
        edge_hold: assert property (@(posedge clk) disable iff (reset)
            edge_valid[i] && !edge_ready[i] |=> edge_valid[i] && $stable(edge_packet[i]))
            else $error("edge PE %0d packet dropped or changed before acceptance", i);
    end

    one_edge_ready: assert property (@(posedge clk) disable iff (reset)
        $onehot0(edge_ready))
        else $error("more than one edge_ready high");

    dp_first: assert property (@(posedge clk) disable iff (reset)
        dp_valid && dp_ready |-> edge_ready == '0)
        else $error("edge PE granted together with the datapath");

    // Two samples cover a cntl_done seen while still in IDLE
    done_blocks: assert property (@(posedge clk) disable iff (reset)
        (cntl_done && !replay_iter) ##1 (cntl_done && !replay_iter)
        |=> !dp_ready && edge_ready == '0)
        else $error("producer accepted after cntl_done");

    // Replay flushes the FIFO, so only the plain case must hold
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !replay_iter |=> out_valid && $stable(out_packet))
        else $error("output packet dropped or changed while out_ready low");

endmodule

bind packet_store_top packet_store_chk #(.NUM_EDGE_PE(NUM_EDGE_PE)) chk (
    .clk         (clk),
    .reset       (reset),
    .dp_valid    (dp_valid),
    .dp_packet   (dp_packet),
    .dp_ready    (dp_ready),
    .edge_valid  (edge_valid),
    .edge_packet (edge_packet),
    .edge_ready  (edge_ready),
    .out_valid   (out_valid),
    .out_packet  (out_packet),
    .out_ready   (out_ready),
    .cntl_done   (cntl_done),
    .replay_iter (replay_iter)
);

// File: verilog/packet_store_top.sv
// Packet store top level
// Datapath and edge PE producers into an SRAM ring, streamed out in order

`timescale 1ns/1ns

module packet_store_top #(
    parameter int DEPTH       = 64,
    parameter int NUM_EDGE_PE = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dp_valid,
    input  pkt_pkg::packet_t        dp_packet,
    output logic                    dp_ready,
    input  logic [NUM_EDGE_PE-1:0]  edge_valid,
    input  pkt_pkg::packet_t        edge_packet [NUM_EDGE_PE],
    output logic [NUM_EDGE_PE-1:0]  edge_ready,
    output logic                    out_valid,
    output pkt_pkg::packet_t        out_packet,
    input  logic                    out_ready,
    input  logic                    cntl_done,
    input  logic                    replay_iter
);

    logic             arb_valid;
    pkt_pkg::packet_t arb_packet;
    logic             arb_ready;
    logic             push;
    pkt_pkg::packet_t push_packet;
    logic             pop;
    logic             flush;

    sram_if #(.DEPTH(DEPTH)) sram_bus ();

    edge_wb_arbiter #(.NUM_EDGE_PE(NUM_EDGE_PE)) u_arb (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid),
        .edge_packet (edge_packet),
        .edge_ready  (edge_ready),
        .arb_valid   (arb_valid),
        .arb_packet  (arb_packet),
        .arb_ready   (arb_ready),
        .flush       (flush)
    );

    packet_cntl #(.DEPTH(DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) u_cntl (
        .clk         (clk),
        .reset       (reset),
        .dp_valid    (dp_valid),
        .dp_packet   (dp_packet),
        .dp_ready    (dp_ready),
        .arb_valid   (arb_valid),
        .arb_packet  (arb_packet),
        .arb_ready   (arb_ready),
        .sram        (sram_bus.cntl),
        .push        (push),
        .push_packet (push_packet),
        .pop         (pop),
        .flush       (flush),
        .cntl_done   (cntl_done),
        .replay_iter (replay_iter)
    );

    packet_sram #(.DEPTH(DEPTH)) u_sram (
        .clk (clk),
        .mem (sram_bus.mem)
    );

    packet_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .push        (push),
        .push_packet (push_packet),
        .pop         (pop),
        .out_valid   (out_valid),
        .out_packet  (out_packet),
        .out_ready   (out_ready)
    );

endmodule

// File: verilog/packet_fifo.sv
// Output packet FIFO
// Small circular buffer between the ring read path and the output stream.
// The controller's credit count keeps pushes within capacity

`timescale 1ns/1ns

module packet_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              push,
    input  pkt_pkg::packet_t  push_packet,
    output logic              pop,
    output logic              out_valid,
    output pkt_pkg::packet_t  out_packet,
    input  logic              out_ready
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pkt_pkg::packet_t mem [FIFO_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign out_valid  = (count != '0);
    assign out_packet = mem[rd_ptr];

    // Output handshake, also returned to the controller as a credit
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop keep the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/packet_cntl.sv
// Packet ring controller
// Writes datapath packets first, then arbitrated edge PE packets, into the
// SRAM ring. Reads the ring into the output FIFO in idle write cycles,
// limited by FIFO credits. Stalls on cntl_done, restarts on replay_iter

`timescale 1ns/1ns

module packet_cntl #(
    parameter int DEPTH      = 64,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dp_valid,
    input  pkt_pkg::packet_t  dp_packet,
    output logic              dp_ready,
    input  logic              arb_valid,
    input  pkt_pkg::packet_t  arb_packet,
    output logic              arb_ready,
    sram_if.cntl              sram,
    output logic              push,
    output pkt_pkg::packet_t  push_packet,
    input  logic              pop,
    output logic              flush,
    input  logic              cntl_done,
    input  logic              replay_iter
);

    localparam int AW = $clog2(DEPTH);
    localparam int OW = $clog2(DEPTH + 1);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pkt_pkg::cntl_state_t state;
    pkt_pkg::cntl_state_t next_state;

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [OW-1:0] occupancy;
    logic [CW-1:0] credit;
    logic          rd_pending;

    logic accepting;
    logic room;
    logic dp_fire;
    logic arb_fire;
    logic wr_fire;
    logic rd_fire;

    // Nothing is accepted in a cycle that replay is about to discard
    assign accepting = (state == pkt_pkg::CNTL_STREAM) && !replay_iter;
    assign room      = (occupancy != OW'(DEPTH));

    // Datapath has fixed priority over the edge PEs
    assign dp_ready  = accepting && room;
    assign arb_ready = accepting && room && !dp_valid;

    assign dp_fire  = dp_valid && dp_ready;
    assign arb_fire = arb_valid && arb_ready;
    assign wr_fire  = dp_fire || arb_fire;

    // Read only in a cycle without a write, with data and FIFO room
    assign rd_fire = accepting && !wr_fire && (occupancy != '0) && (credit != '0);

    // SRAM port, one access per cycle
    assign sram.wen   = wr_fire;
    assign sram.ren   = rd_fire;
    assign sram.addr  = wr_fire ? wr_ptr : rd_ptr;
    assign sram.wdata = dp_fire ? dp_packet : arb_packet;

    // Read data lands one cycle after ren
    assign push        = rd_pending;
    assign push_packet = sram.rdata;

    // FIFO and arbiter restart with the controller
    assign flush = replay_iter;

    always_comb begin
        next_state = state;
        case (state)
            pkt_pkg::CNTL_IDLE: begin
                next_state = pkt_pkg::CNTL_STREAM;
            end
            pkt_pkg::CNTL_STREAM: begin
                if (cntl_done) begin
                    next_state = pkt_pkg::CNTL_STALL;
                end
            end
            pkt_pkg::CNTL_STALL: begin
                // held until replay or reset
                next_state = pkt_pkg::CNTL_STALL;
            end
            default: begin
                next_state = pkt_pkg::CNTL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || replay_iter) begin
            state      <= pkt_pkg::CNTL_IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occupancy  <= '0;
            credit     <= CW'(FIFO_DEPTH);
            rd_pending <= 1'b0;
        end else begin
            state      <= next_state;
            rd_pending <= rd_fire;

            if (wr_fire) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Writes and reads never share a cycle
            if (wr_fire) begin
                occupancy <= occupancy + 1'b1;
            end else if (rd_fire) begin
                occupancy <= occupancy - 1'b1;
            end

            // A credit covers one read in flight or one FIFO entry
            credit <= credit - CW'(rd_fire) + CW'(pop);
        end
    end

endmodule

// File: verilog/edge_wb_arbiter.sv
// Edge PE write-back arbiter
// Round-robin pick of one valid edge PE per cycle, forwarded to the
// packet controller. Pointer advances only on an accepted transfer

`timescale 1ns/1ns

module edge_wb_arbiter #(
    parameter int NUM_EDGE_PE = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [NUM_EDGE_PE-1:0]  edge_valid,
    input  pkt_pkg::packet_t        edge_packet [NUM_EDGE_PE],
    output logic [NUM_EDGE_PE-1:0]  edge_ready,
    output logic                    arb_valid,
    output pkt_pkg::packet_t        arb_packet,
    input  logic                    arb_ready,
    input  logic                    flush
);

    localparam int IDX_W = (NUM_EDGE_PE > 1) ? $clog2(NUM_EDGE_PE) : 1;

    logic [IDX_W-1:0] last_grant;
    logic [IDX_W-1:0] grant_idx;
    logic             found;

    // Search starts one past the last granted index
    always_comb begin
        int cand;
        found     = 1'b0;
        grant_idx = '0;
        for (int off = 1; off <= NUM_EDGE_PE; off++) begin
            cand = (int'(last_grant) + off) % NUM_EDGE_PE;
            if (!found && edge_valid[cand]) begin
                found     = 1'b1;
                grant_idx = IDX_W'(cand);
            end
        end
    end

    assign arb_valid  = found;
    assign arb_packet = edge_packet[grant_idx];

    // One-hot ready back to the granted PE only
    always_comb begin
        edge_ready = '0;
        if (found && arb_ready) begin
            edge_ready[grant_idx] = 1'b1;
        end
    end

    // Last index so that the first search after reset starts at PE 0
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            last_grant <= IDX_W'(NUM_EDGE_PE - 1);
        end else if (arb_valid && arb_ready) begin
            last_grant <= grant_idx;
        end
    end

endmodule

// File: verilog/packet_sram.sv
// Packet ring storage
// Single-port synchronous SRAM with a registered read port
// rdata holds its value until the next read

`timescale 1ns/1ns

module packet_sram #(
    parameter int DEPTH = 64
) (
    input  logic  clk,
    sram_if.mem   mem
);

    pkt_pkg::packet_t ram [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (mem.wen) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // One-cycle read latency, held between reads
    always_ff @(posedge clk) begin
        if (mem.ren) begin
            mem.rdata <= ram[mem.addr];
        end
    end

endmodule

// File: verilog/sram_if.sv
// Packet controller to SRAM port
// Single port, one access per cycle, read data one cycle after ren

`timescale 1ns/1ns

interface sram_if #(
    parameter int DEPTH = 64
);
    localparam int AW = $clog2(DEPTH);

    logic               wen;
    logic               ren;
    logic [AW-1:0]      addr;
    pkt_pkg::packet_t   wdata;
    pkt_pkg::packet_t   rdata;

    modport cntl (output wen, ren, addr, wdata, input rdata);

    modport mem (input wen, ren, addr, wdata, output rdata);

endinterface

// File: verilog/pkt_pkg.sv
// Packet store shared definitions
// Packet word type and the packet controller state encoding

package pkt_pkg;

    // Width of one stored packet word
    localparam int PACKET_W = 32;

    // One packet as held in the ring and the output FIFO
    typedef logic [PACKET_W-1:0] packet_t;

    // Packet controller FSM
    // IDLE waits one cycle after reset or replay
    // STREAM accepts writes and issues reads
    // STALL holds until the next iteration
    typedef enum logic [1:0] {
        CNTL_IDLE   = 2'd0,
        CNTL_STREAM = 2'd1,
        CNTL_STALL  = 2'd2
    } cntl_state_t;

endpackage
